/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = tb_addr_unit
FILELIST  = files.f

SOURCES   = $(shell grep -v '^+' $(FILELIST))
BIN       = obj_dir/V$(TOP)
LOG       = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
src/m68k_arch_pkg.sv
src/m68k_ea_pkg.sv
src/addr_reg_file.sv
src/ea_ext_regs.sv
src/ea_calc.sv
src/program_counter.sv
src/addr_unit.sv
test/addr_unit_props.sv
test/tb_addr_unit.sv

/* src/addr_reg_file.sv */
`timescale 1ns/1ps

module addr_reg_file
    import m68k_arch_pkg::*;
#(
    parameter logic [ADDR_W-1:0] SP_RESET = '0
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic [ADDR_W-1:0] ar_in_1,
    input  logic [2:0]        ar_sel_rd_1,
    input  logic [2:0]        ar_sel_rd_2,
    input  logic [2:0]        ar_sel_wr,
    input  logic              ar_wr,
    input  logic              ar_inc,
    input  logic              ar_dec,
    input  op_size_t          op_size,
    input  logic              sbit,
    input  logic              mbit,
    input  logic [2:0]        index_sel,   // Brief word index register
    output logic [ADDR_W-1:0] ar_out_1,
    output logic [ADDR_W-1:0] ar_out_2,
    output logic [ADDR_W-1:0] base_reg,
    output logic [ADDR_W-1:0] index_an
);

    localparam logic [2:0] SP_SEL = 3'(NUM_AREGS);  // A7

    logic [ADDR_W-1:0] ar [NUM_AREGS];          // A0 to A6
    logic [ADDR_W-1:0] sp [3];                  // Indexed by sp_bank_t
    logic [ADDR_W-1:0] areg_view [NUM_AREGS+1]; // A0 to A7 as seen now
    sp_bank_t          bank;
    logic [2:0]        step_amt;
    logic [ADDR_W-1:0] step_val;

    // --------------------
    // Stack pointer bank
    // --------------------
    always_comb begin
        if (!sbit)
            bank = USP;
        else if (mbit)
            bank = MSP;   // Master mode
        else
            bank = ISP;
    end

    always_comb begin
        for (int i = 0; i < NUM_AREGS; i++)
            areg_view[i] = ar[i];
        areg_view[NUM_AREGS] = sp[bank];  // A7 follows S and M
    end

    // Read ports
    assign ar_out_1 = areg_view[ar_sel_rd_1];
    assign ar_out_2 = areg_view[ar_sel_rd_2];
    assign base_reg = ar_out_1;
    assign index_an = areg_view[index_sel];

    // --------------------
    // Step size
    // --------------------
    always_comb begin
        case (op_size)
            BYTE:    step_amt = (ar_sel_rd_1 == SP_SEL) ? 3'd2 : 3'd1;  // Keep SP word aligned
            WORD:    step_amt = 3'd2;
            default: step_amt = 3'd4;
        endcase
    end

    // Inc wins if both are set
    assign step_val = ar_inc ? ar_out_1 + ADDR_W'(step_amt)
                             : ar_out_1 - ADDR_W'(step_amt);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < NUM_AREGS; i++)
                ar[i] <= '0;
            for (int i = 0; i < 3; i++)
                sp[i] <= SP_RESET;
        end else begin
            // Write port, always long
            if (ar_wr) begin
                if (ar_sel_wr == SP_SEL)
                    sp[bank] <= ar_in_1;  // Bank from current S and M
                else
                    ar[ar_sel_wr] <= ar_in_1;
            end
            // Later assignment so a step beats a write to the same register
            if (ar_inc || ar_dec) begin
                if (ar_sel_rd_1 == SP_SEL)
                    sp[bank] <= step_val;
                else
                    ar[ar_sel_rd_1] <= step_val;
            end
        end
    end

endmodule

/* src/addr_unit.sv */
`timescale 1ns/1ps

module addr_unit
    import m68k_arch_pkg::*, m68k_ea_pkg::*;
#(
    parameter logic [ADDR_W-1:0] PC_RESET = '0,  // PC after reset
    parameter logic [ADDR_W-1:0] SP_RESET = '0   // All three stack pointers after reset
) (
    input  logic              CLK,
    input  logic              RESET,

    // Register file
    input  logic [ADDR_W-1:0] ar_in_1,
    input  logic [ADDR_W-1:0] index_in,
    input  logic [ADDR_W-1:0] displacement,
    input  logic [2:0]        ar_sel_rd_1,
    input  logic [2:0]        ar_sel_rd_2,
    input  logic [2:0]        ar_sel_wr,
    input  logic              ar_wr,
    input  logic              ar_inc,
    input  logic              ar_dec,
    input  op_size_t          op_size,
    input  logic              sbit,
    input  logic              mbit,

    // Extension words and mode
    input  ext_word_u         ext_word,
    input  logic              store_brief,
    input  logic              store_d16,
    input  logic              store_abs_lo,
    input  logic              store_abs_hi,
    input  adr_mode_t         adr_mode,
    input  amode_sel_t        amode_sel,

    // Program counter
    input  logic [3:0]        pc_ew_offset,
    input  logic [7:0]        pc_offset,
    input  logic              pc_load,
    input  logic              pc_add_displ,
    input  logic              pc_inc,

    output logic [ADDR_W-1:0] ar_out_1,
    output logic [ADDR_W-1:0] ar_out_2,
    output logic [ADDR_W-1:0] adr_eff,
    output logic [ADDR_W-1:0] pc
);

    logic [ADDR_W-1:0] base_reg;      // Port 1 register, banked for A7
    logic [ADDR_W-1:0] index_an;      // An named by the brief word
    logic [2:0]        index_sel;
    logic [ADDR_W-1:0] base_displ;
    logic [ADDR_W-1:0] index_scaled;
    logic [ADDR_W-1:0] abs_adr;

    addr_reg_file #(.SP_RESET(SP_RESET)) u_reg_file (
        .CLK(CLK), .RESET(RESET),
        .ar_in_1(ar_in_1), .ar_sel_rd_1(ar_sel_rd_1), .ar_sel_rd_2(ar_sel_rd_2),
        .ar_sel_wr(ar_sel_wr), .ar_wr(ar_wr), .ar_inc(ar_inc), .ar_dec(ar_dec),
        .op_size(op_size), .sbit(sbit), .mbit(mbit), .index_sel(index_sel),
        .ar_out_1(ar_out_1), .ar_out_2(ar_out_2), .base_reg(base_reg), .index_an(index_an)
    );

    ea_ext_regs u_ext_regs (
        .CLK(CLK), .RESET(RESET),
        .ext_word(ext_word), .store_brief(store_brief), .store_d16(store_d16),
        .store_abs_lo(store_abs_lo), .store_abs_hi(store_abs_hi), .amode_sel(amode_sel),
        .index_in(index_in), .index_an(index_an), .index_sel(index_sel),
        .base_displ(base_displ), .index_scaled(index_scaled), .abs_adr(abs_adr)
    );

    ea_calc u_ea_calc (
        .CLK(CLK), .RESET(RESET),
        .adr_mode(adr_mode), .amode_sel(amode_sel), .base_reg(base_reg),
        .base_displ(base_displ), .index_scaled(index_scaled), .abs_adr(abs_adr),
        .pc(pc), .pc_ew_offset(pc_ew_offset), .adr_eff(adr_eff)
    );

    program_counter #(.PC_RESET(PC_RESET)) u_pc (
        .CLK(CLK), .RESET(RESET),
        .ar_in_1(ar_in_1), .displacement(displacement), .pc_offset(pc_offset),
        .pc_load(pc_load), .pc_add_displ(pc_add_displ), .pc_inc(pc_inc), .pc(pc)
    );

endmodule

/* src/ea_calc.sv */
`timescale 1ns/1ps

module ea_calc
    import m68k_arch_pkg::*, m68k_ea_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  adr_mode_t         adr_mode,
    input  amode_sel_t        amode_sel,
    input  logic [ADDR_W-1:0] base_reg,
    input  logic [ADDR_W-1:0] base_displ,
    input  logic [ADDR_W-1:0] index_scaled,
    input  logic [ADDR_W-1:0] abs_adr,
    input  logic [ADDR_W-1:0] pc,
    input  logic [3:0]        pc_ew_offset,  // Byte offset of the extension word
    output logic [ADDR_W-1:0] adr_eff
);

    logic [ADDR_W-1:0] pc_ext;   // Address of the extension word
    logic [ADDR_W-1:0] ea_next;

    assign pc_ext = pc + ADDR_W'(pc_ew_offset);

    // --------------------
    // Address by mode
    // --------------------
    always_comb begin
        case (adr_mode)
            ADR_AN_IND, ADR_AN_POST, ADR_AN_PRE:
                ea_next = base_reg;  // Step happens in the register file
            ADR_AN_DISP:
                ea_next = base_reg + base_displ;
            ADR_AN_IDX:
                ea_next = base_reg + base_displ + index_scaled;
            ADR_SPECIAL: begin
                case (amode_sel)
                    ABS_W, ABS_L: ea_next = abs_adr;  // Already sign filled for .W
                    PC_DISP:      ea_next = pc_ext + base_displ;
                    default:      ea_next = '0;
                endcase
            end
            default:
                ea_next = '0;  // Register direct modes
        endcase
    end

    // Registered every cycle
    always_ff @(posedge CLK) begin
        if (RESET)
            adr_eff <= '0;
        else
            adr_eff <= ea_next;
    end

endmodule

/* src/ea_ext_regs.sv */
`timescale 1ns/1ps

module ea_ext_regs
    import m68k_arch_pkg::*, m68k_ea_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  ext_word_u         ext_word,
    input  logic              store_brief,
    input  logic              store_d16,
    input  logic              store_abs_lo,
    input  logic              store_abs_hi,
    input  amode_sel_t        amode_sel,
    input  logic [ADDR_W-1:0] index_in,     // Dn from the data side
    input  logic [ADDR_W-1:0] index_an,     // An from the register file
    output logic [2:0]        index_sel,
    output logic [ADDR_W-1:0] base_displ,
    output logic [ADDR_W-1:0] index_scaled,
    output logic [ADDR_W-1:0] abs_adr
);

    logic [ADDR_W-1:0] index_src;
    logic [ADDR_W-1:0] index_reg;
    logic [1:0]        scale_reg;

    assign index_sel = ext_word.brief.reg_no;  // Register file looks it up this cycle
    assign index_src = ext_word.brief.da ? index_an : index_in;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            base_displ <= '0;
            index_reg  <= '0;
            scale_reg  <= '0;
            abs_adr    <= '0;
        end else begin
            // --------------------
            // Displacement and index
            // --------------------
            if (store_brief) begin
                base_displ <= {{(ADDR_W-8){ext_word.brief.disp8[7]}}, ext_word.brief.disp8};
                if (ext_word.brief.wl)
                    index_reg <= index_src;
                else
                    index_reg <= {{(ADDR_W-16){index_src[15]}}, index_src[15:0]};  // Word index
                scale_reg <= ext_word.brief.scale;
            end else if (store_d16) begin
                base_displ <= {{(ADDR_W-16){ext_word.d16[15]}}, ext_word.d16};
            end

            // Absolute address
            if (store_abs_lo) begin
                if (amode_sel == ABS_W)
                    abs_adr[ADDR_W-1:16] <= {(ADDR_W-16){ext_word.d16[15]}};  // Sign fill
                abs_adr[15:0] <= ext_word.d16;
            end else if (store_abs_hi) begin
                abs_adr[ADDR_W-1:16] <= ext_word.d16;
            end
        end
    end

    assign index_scaled = index_reg << scale_reg;  // x1, x2, x4, x8

endmodule

/* src/m68k_arch_pkg.sv */
package m68k_arch_pkg;

    // --------------------
    // Register file sizes
    // --------------------
    localparam int ADDR_W    = 32;  // Address and register width
    localparam int NUM_AREGS = 7;   // A0 to A6, index 7 names the active stack pointer

    // Operand size of the current access
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        WORD = 2'd1,
        LONG = 2'd2
    } op_size_t;

    // Stack pointer that A7 refers to
    typedef enum logic [1:0] {
        USP = 2'd0,  // User mode
        ISP = 2'd1,  // Supervisor, master bit clear
        MSP = 2'd2   // Supervisor, master bit set
    } sp_bank_t;

endpackage

/* src/m68k_ea_pkg.sv */
package m68k_ea_pkg;

    // --------------------
    // Mode field codes
    // --------------------
    typedef enum logic [2:0] {
        ADR_AN_IND  = 3'd2,  // (An)
        ADR_AN_POST = 3'd3,  // (An)+
        ADR_AN_PRE  = 3'd4,  // -(An)
        ADR_AN_DISP = 3'd5,  // (d16,An)
        ADR_AN_IDX  = 3'd6,  // (d8,An,Xn)
        ADR_SPECIAL = 3'd7   // Abs and PC relative, see amode_sel_t
    } adr_mode_t;

    // Register field when the mode is ADR_SPECIAL
    typedef enum logic [2:0] {
        ABS_W   = 3'd0,  // (xxx).W
        ABS_L   = 3'd1,  // (xxx).L
        PC_DISP = 3'd2   // (d16,PC)
    } amode_sel_t;

    // --------------------
    // Extension word
    // --------------------
    typedef struct packed {
        logic       da;      // Index is An
        logic [2:0] reg_no;  // Index register number
        logic       wl;      // Long index
        logic [1:0] scale;   // Index scale 1, 2, 4, 8
        logic       fmt;     // Zero for the brief format
        logic [7:0] disp8;   // Signed displacement
    } brief_ext_t;

    // Same 16 bits seen as brief word or as d16
    typedef union packed {
        brief_ext_t         brief;
        logic signed [15:0] d16;
    } ext_word_u;

endpackage

/* src/program_counter.sv */
`timescale 1ns/1ps

module program_counter
    import m68k_arch_pkg::*;
#(
    parameter logic [ADDR_W-1:0] PC_RESET = '0
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic [ADDR_W-1:0] ar_in_1,       // Jump target
    input  logic [ADDR_W-1:0] displacement,  // Branch displacement
    input  logic [7:0]        pc_offset,     // Bytes consumed by the opcode
    input  logic              pc_load,
    input  logic              pc_add_displ,
    input  logic              pc_inc,
    output logic [ADDR_W-1:0] pc
);

    // Load and branch beat inc, which comes with them on a pipe flush
    always_ff @(posedge CLK) begin
        if (RESET)
            pc <= PC_RESET;
        else if (pc_load)
            pc <= ar_in_1;
        else if (pc_add_displ)
            pc <= pc + displacement;
        else if (pc_inc)
            pc <= pc + ADDR_W'(pc_offset);  // Zero extended
    end

endmodule

/* test/addr_unit_props.sv */
`timescale 1ns/1ps

module addr_unit_props
    import m68k_arch_pkg::*;
(
    input logic              CLK,
    input logic              RESET,
    input logic [ADDR_W-1:0] ar_in_1,
    input logic [2:0]        ar_sel_rd_1,
    input logic              ar_inc,
    input logic              ar_dec,
    input op_size_t          op_size,
    input logic              sbit,
    input logic              mbit,
    input logic [ADDR_W-1:0] ar_out_1,
    input logic [7:0]        pc_offset,
    input logic              pc_load,
    input logic              pc_add_displ,
    input logic              pc_inc,
    input logic [ADDR_W-1:0] pc
);

    // --------------------
    // Program counter
    // --------------------
    pc_inc_alone: assert property (@(posedge CLK) disable iff (RESET)
        pc_inc && !pc_load && !pc_add_displ |=> pc == $past(pc) + ADDR_W'($past(pc_offset)))
        else $error("pc_inc alone did not add pc_offset");

    pc_load_wins: assert property (@(posedge CLK) disable iff (RESET)
        pc_load |=> pc == $past(ar_in_1))
        else $error("pc_load did not take priority");

    // Byte step of A7, checked only while the same bank stays selected
    sp_byte_step: assert property (@(posedge CLK) disable iff (RESET)
        ar_inc && !ar_dec && ar_sel_rd_1 == 3'd7 && op_size == BYTE |=>
            ar_sel_rd_1 != 3'd7 || sbit != $past(sbit) || mbit != $past(mbit)
            || ar_out_1 == $past(ar_out_1) + 32'd2)
        else $error("byte step of the stack pointer did not move it by 2");

endmodule

bind addr_unit addr_unit_props u_props (
    .CLK(CLK), .RESET(RESET), .ar_in_1(ar_in_1), .ar_sel_rd_1(ar_sel_rd_1),
    .ar_inc(ar_inc), .ar_dec(ar_dec), .op_size(op_size), .sbit(sbit), .mbit(mbit),
    .ar_out_1(ar_out_1), .pc_offset(pc_offset), .pc_load(pc_load),
    .pc_add_displ(pc_add_displ), .pc_inc(pc_inc), .pc(pc)
);

/* test/tb_addr_unit.sv */
`timescale 1ns/1ps

module tb_addr_unit
    import m68k_arch_pkg::*, m68k_ea_pkg::*;
();

    localparam logic [ADDR_W-1:0] PC_RST  = 32'h0000_0400;
    localparam logic [ADDR_W-1:0] SP_RST  = 32'h0000_7FF0;
    localparam int                TIMEOUT = 50;  // Cycles to drain pending checks

    logic              CLK, RESET;
    logic [ADDR_W-1:0] ar_in_1, index_in, displacement;
    logic [2:0]        ar_sel_rd_1, ar_sel_rd_2, ar_sel_wr;
    logic              ar_wr, ar_inc, ar_dec;
    op_size_t          op_size;
    logic              sbit, mbit;
    ext_word_u         ext_word;
    logic              store_brief, store_d16, store_abs_lo, store_abs_hi;
    adr_mode_t         adr_mode;
    amode_sel_t        amode_sel;
    logic [3:0]        pc_ew_offset;
    logic [7:0]        pc_offset;
    logic              pc_load, pc_add_displ, pc_inc;
    logic [ADDR_W-1:0] ar_out_1, ar_out_2, adr_eff, pc;

    // Shadow copy of the architectural state
    logic [ADDR_W-1:0] sh_ar [NUM_AREGS];
    logic [ADDR_W-1:0] sh_sp [3];         // USP, ISP, MSP
    logic [ADDR_W-1:0] sh_pc;
    integer            seed = 66;
    int                checks_done = 0;

    // Pending checks, pushed on falling edges
    string             name_q [$];
    logic [ADDR_W-1:0] exp_q [$];
    logic [ADDR_W-1:0] act_q [$];

    addr_unit #(.PC_RESET(PC_RST), .SP_RESET(SP_RST)) UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;  // 8 ns period
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [1:0] bank_of(input logic s, input logic m);
        if (!s)
            return 2'd0;  // User
        return m ? 2'd2 : 2'd1;
    endfunction

    function automatic logic [ADDR_W-1:0] shadow_of(input logic [2:0] sel, input logic s, m);
        return (sel == 3'd7) ? sh_sp[bank_of(s, m)] : sh_ar[sel];
    endfunction

    function automatic logic [ADDR_W-1:0] sext16(input logic [15:0] w);
        return {{16{w[15]}}, w};
    endfunction

    // Expected effective address from the mode rules
    function automatic logic [ADDR_W-1:0] ref_ea(
        input adr_mode_t mode, input amode_sel_t sel, input logic [ADDR_W-1:0] base,
        input ext_word_u ext, input logic [ADDR_W-1:0] idx, input logic [ADDR_W-1:0] abs_val,
        input logic [ADDR_W-1:0] pc_val, input logic [3:0] ew_off);
        logic [ADDR_W-1:0] xn;
        xn = ext.brief.wl ? idx : sext16(idx[15:0]);  // Word index is sign extended
        case (mode)
            ADR_AN_IND, ADR_AN_POST, ADR_AN_PRE: return base;
            ADR_AN_DISP: return base + sext16(ext.d16);
            ADR_AN_IDX:
                return base + {{24{ext.brief.disp8[7]}}, ext.brief.disp8}
                       + xn * (32'd1 << ext.brief.scale);
            ADR_SPECIAL:
                return (sel == PC_DISP) ? pc_val + ADDR_W'(ew_off) + sext16(ext.d16) : abs_val;
            default: return '0;
        endcase
    endfunction

    // Next PC, load first, then branch, then increment
    function automatic logic [ADDR_W-1:0] ref_pc(
        input logic [ADDR_W-1:0] cur, input logic ld, add, inc,
        input logic [ADDR_W-1:0] target, displ, input logic [7:0] off);
        if (ld)
            return target;
        if (add)
            return cur + displ;
        if (inc)
            return cur + {24'd0, off};
        return cur;
    endfunction

    // --------------------
    // Checking
    // --------------------
    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic expect_eq(input string name, input logic [ADDR_W-1:0] exp_val, act_val);
        name_q.push_back(name);
        exp_q.push_back(exp_val);
        act_q.push_back(act_val);
    endtask

    // Compares on rising edges what the stimulus sampled on falling edges
    always @(posedge CLK) begin
        while (exp_q.size() > 0) begin
            assert (act_q[0] === exp_q[0]) else
                stop_on_error($sformatf("FAIL %s expected %h actual %h",
                                        name_q[0], exp_q[0], act_q[0]));
            void'(name_q.pop_front());
            void'(exp_q.pop_front());
            void'(act_q.pop_front());
            checks_done++;
        end
    end

    task automatic drain_checks;
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            @(negedge CLK);
            waited++;
            if (waited > TIMEOUT)
                stop_on_error("Pending checks were never compared before the timeout");
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic idle(input int n);
        for (int i = 0; i < n; i++)
            @(negedge CLK);
    endtask

    task automatic set_shadow(input logic [2:0] sel, input logic s, m,
                              input logic [ADDR_W-1:0] val);
        if (sel == 3'd7)
            sh_sp[bank_of(s, m)] = val;
        else
            sh_ar[sel] = val;
    endtask

    task automatic check_reads(input logic [2:0] sel1, sel2, input logic s, m, input string name);
        ar_sel_rd_1 = sel1;
        ar_sel_rd_2 = sel2;
        sbit        = s;
        mbit        = m;
        @(negedge CLK);  // Ports settle, nothing strobed meanwhile
        expect_eq({name, " port 1"}, shadow_of(sel1, s, m), ar_out_1);
        expect_eq({name, " port 2"}, shadow_of(sel2, s, m), ar_out_2);
    endtask

    task automatic write_areg(input logic [2:0] sel, input logic s, m,
                              input logic [ADDR_W-1:0] val);
        ar_sel_wr = sel;
        ar_in_1   = val;
        ar_wr     = 1'b1;
        sbit      = s;
        mbit      = m;
        @(negedge CLK);
        ar_wr = 1'b0;
        set_shadow(sel, s, m, val);
    endtask

    // Step the port 1 register, optionally racing a write to it
    task automatic step_areg(input logic [2:0] sel, input op_size_t size, input logic up, with_wr);
        logic [ADDR_W-1:0] amt;
        logic [ADDR_W-1:0] old;
        amt = (size == LONG) ? 32'd4 : (size == WORD || sel == 3'd7) ? 32'd2 : 32'd1;
        old = shadow_of(sel, sbit, mbit);
        ar_sel_rd_1 = sel;
        op_size     = size;
        ar_inc      = up;
        ar_dec      = !up;
        ar_sel_wr   = sel;
        ar_in_1     = $random(seed);
        ar_wr       = with_wr;
        @(negedge CLK);
        ar_inc = 1'b0;
        ar_dec = 1'b0;
        ar_wr  = 1'b0;
        set_shadow(sel, sbit, mbit, up ? old + amt : old - amt);
    endtask

    // Store the extension words a mode needs, hold the selects, check adr_eff
    task automatic run_ea(input string name, input adr_mode_t mode, input amode_sel_t sel,
                          input logic [2:0] base_sel, input ext_word_u ext,
                          input logic [ADDR_W-1:0] xval);
        logic [ADDR_W-1:0] idx;
        logic [ADDR_W-1:0] abs_val;
        logic [ADDR_W-1:0] exp_val;
        adr_mode     = mode;
        amode_sel    = sel;
        ar_sel_rd_1  = base_sel;
        index_in     = xval;  // Data register index
        pc_ew_offset = 4'($random(seed));
        if (mode == ADR_SPECIAL && sel == ABS_L) begin
            ext_word.d16 = xval[31:16];  // High word first
            store_abs_hi = 1'b1;
            @(negedge CLK);
            store_abs_hi = 1'b0;
            ext_word.d16 = xval[15:0];
            store_abs_lo = 1'b1;
            abs_val      = xval;
        end else begin
            ext_word     = ext;
            store_brief  = (mode == ADR_AN_IDX);
            store_d16    = (mode == ADR_AN_DISP) || (mode == ADR_SPECIAL && sel == PC_DISP);
            store_abs_lo = (mode == ADR_SPECIAL && sel == ABS_W);
            abs_val      = sext16(ext.d16);  // Short absolute is sign filled
        end
        idx = ext.brief.da ? shadow_of(ext.brief.reg_no, sbit, mbit) : xval;
        exp_val = ref_ea(mode, sel, shadow_of(base_sel, sbit, mbit), ext, idx, abs_val,
                         sh_pc, pc_ew_offset);
        @(negedge CLK);  // Edge k captures
        store_brief  = 1'b0;
        store_d16    = 1'b0;
        store_abs_lo = 1'b0;
        idle(2);         // Edges k+1 and k+2
        expect_eq(name, exp_val, adr_eff);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [2:0] sel;
        ext_word_u  ext;
        RESET        = 1'b1;
        ar_in_1      = '0;
        index_in     = '0;
        displacement = '0;
        ar_sel_rd_1  = '0;
        ar_sel_rd_2  = '0;
        ar_sel_wr    = '0;
        ar_wr        = 1'b0;
        ar_inc       = 1'b0;
        ar_dec       = 1'b0;
        op_size      = LONG;
        sbit         = 1'b0;
        mbit         = 1'b0;
        ext_word     = '0;
        store_brief  = 1'b0;
        store_d16    = 1'b0;
        store_abs_lo = 1'b0;
        store_abs_hi = 1'b0;
        adr_mode     = ADR_AN_IND;
        amode_sel    = ABS_W;
        pc_ew_offset = '0;
        pc_offset    = '0;
        pc_load      = 1'b0;
        pc_add_displ = 1'b0;
        pc_inc       = 1'b0;
        for (int i = 0; i < NUM_AREGS; i++)
            sh_ar[i] = '0;
        for (int i = 0; i < 3; i++)
            sh_sp[i] = SP_RST;
        sh_pc = PC_RST;
        idle(10);
        RESET = 1'b0;

        // Reset values on both ports and all banks
        expect_eq("reset pc", PC_RST, pc);
        for (int r = 0; r < 8; r++)
            check_reads(3'(r), 3'(7 - r), r[0], r[1], "reset read");

        // Random writes, then one value per stack pointer
        for (int i = 0; i < 24; i++) begin
            sel = 3'($random(seed));
            write_areg(sel, 1'($random(seed)), 1'($random(seed)), $random(seed));
            check_reads(sel, 3'($random(seed)), sbit, mbit, "write readback");
        end
        write_areg(3'd7, 1'b0, 1'b0, $random(seed));
        write_areg(3'd7, 1'b1, 1'b0, $random(seed));
        write_areg(3'd7, 1'b1, 1'b1, $random(seed));
        check_reads(3'd7, 3'd7, 1'b0, 1'b0, "usp kept");
        check_reads(3'd7, 3'd7, 1'b1, 1'b0, "isp kept");
        check_reads(3'd7, 3'd7, 1'b1, 1'b1, "msp kept");
        check_reads(3'd7, 3'd7, 1'b0, 1'b1, "usp with m set");

        // Steps in all sizes, A7 once per bank
        for (int r = 0; r < 10; r++) begin
            sel  = (r > 7) ? 3'd7 : 3'(r);
            sbit = (r > 7);
            mbit = (r == 9);
            for (int z = 0; z < 3; z++) begin
                step_areg(sel, op_size_t'(z), 1'b1, z == 2);
                check_reads(sel, sel, sbit, mbit, "step up");
                step_areg(sel, op_size_t'(z), 1'b0, z != 2);
                check_reads(sel, sel, sbit, mbit, "step down");
            end
        end

        // Register based modes
        for (int i = 0; i < 40; i++) begin
            sel  = 3'($random(seed));
            sbit = 1'($random(seed));
            mbit = 1'($random(seed));
            ext.d16 = 16'($random(seed));
            run_ea("an indirect", adr_mode_t'(2 + i % 3), ABS_W, sel, ext, '0);
            run_ea("d16 an", ADR_AN_DISP, ABS_W, sel, ext, '0);
            ext.brief.fmt = 1'b0;  // Brief format
            run_ea("brief index", ADR_AN_IDX, ABS_W, sel, ext, $random(seed));
        end

        // Absolute and PC relative
        for (int i = 0; i < 16; i++) begin
            ext.d16 = 16'($random(seed));
            run_ea("abs long", ADR_SPECIAL, ABS_L, 3'd0, ext, $random(seed));
            run_ea("abs short", ADR_SPECIAL, ABS_W, 3'd0, ext, '0);
            run_ea("pc d16", ADR_SPECIAL, PC_DISP, 3'd0, ext, '0);
        end

        // PC strobes, every combination
        for (int i = 0; i < 32; i++) begin
            ar_in_1      = $random(seed);
            displacement = $random(seed);
            pc_offset    = 8'($random(seed));
            pc_load      = i[0];
            pc_add_displ = i[1];
            pc_inc       = i[2];
            sh_pc = ref_pc(sh_pc, pc_load, pc_add_displ, pc_inc, ar_in_1, displacement,
                           pc_offset);
            @(negedge CLK);
            pc_load      = 1'b0;
            pc_add_displ = 1'b0;
            pc_inc       = 1'b0;
            expect_eq("pc strobes", sh_pc, pc);
        end

        drain_checks();
        if (checks_done > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error("No check was compared during the run");
        end
    end

endmodule
